// File: Bender.yml
package:
  name: cgra_tile

sources:
  # package first, then the blocks, then the tile that joins them.
  - files:
      - logic/cgra_pkg.sv
      - logic/switch_box.sv
      - logic/connection_box.sv
      - logic/pe_core.sv
      - logic/config_loader.sv
      - logic/cgra_tile.sv

  - target: test
    files:
      - dv/cgra_tile_checks.sv
      - dv/cgra_tile_tb.sv

// File: cgra_tile.f
logic/cgra_pkg.sv
logic/switch_box.sv
logic/connection_box.sv
logic/pe_core.sv
logic/config_loader.sv
logic/cgra_tile.sv
dv/cgra_tile_checks.sv
dv/cgra_tile_tb.sv

// File: dv/cgra_tile_checks.sv
module cgra_tile_checks #(
	parameter int unsigned TILE_ID = 5
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cfg_we_i,
	input  logic                   cfg_re_i,
	input  cgra_pkg::cfg_addr_t    cfg_addr_i,
	input  cgra_pkg::cfg_word_u    cfg_wdata_i,
	input  cgra_pkg::tile_tracks_t in_tracks_i,
	input  cgra_pkg::tile_tracks_t out_tracks_i,
	input  cgra_pkg::cfg_word_u    cfg_rdata_i,
	input  logic                   cfg_err_i,
	output int                     fail_cnt_o
);

	import cgra_pkg::*;

	cfg_word_u    sb_sh;
	cfg_word_u    cb_sh;
	cfg_word_u    pe_sh;
	cfg_word_u    exp_rdata;
	logic         exp_err;
	logic         hit;
	track_t       op_a;
	track_t       op_b;
	track_t       pe_now;
	track_t       pe_q;
	track_t       pe_exp;
	tile_tracks_t exp_out;
	int           fail_cnt = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic side_t side_at(tile_tracks_t tr, int s);
		case (s)
			0: return tr.north;
			1: return tr.east;
			2: return tr.south;
			default: return tr.west;
		endcase
	endfunction

	function automatic tile_tracks_t route(sb_cfg_t sel, tile_tracks_t tr, track_t pe);
		side_t o [NUM_SIDES];
		side_t src;
		int    k;
		for (int s = 0; s < NUM_SIDES; s++) begin
			for (int t = 0; t < NUM_TRACKS; t++) begin
				k = sel[s*NUM_TRACKS + t];
				src = side_at(tr, (s + 1 + k) % NUM_SIDES);
				o[s].trk[t] = (k == 3) ? pe : src.trk[(t + s + k) % NUM_TRACKS];
			end
		end
		return {o[0], o[1], o[2], o[3]}; // north is the top field.
	endfunction

	function automatic track_t operand(tile_tracks_t tr, logic [3:0] v);
		side_t src;
		src = side_at(tr, v / NUM_TRACKS);
		return src.trk[v % NUM_TRACKS];
	endfunction

	function automatic track_t pe_calc(pe_op_e op, track_t a, track_t b, track_t c);
		case (op)
			PASS_A:  return a;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			ADD:     return track_t'(a + b);
			SUB:     return track_t'(a - b);
			CONST:   return c;
			default: return ~a;
		endcase
	endfunction

	assign hit     = (cfg_addr_i.tile == 6'(TILE_ID));
	assign op_a    = operand(in_tracks_i, cb_sh.cb.sel_a);
	assign op_b    = operand(in_tracks_i, cb_sh.cb.sel_b);
	assign pe_now  = pe_calc(pe_sh.pe.op, op_a, op_b, pe_sh.pe.const_val);
	assign pe_exp  = pe_sh.pe.out_reg ? pe_q : pe_now;
	assign exp_out = route(sb_sh.sb, in_tracks_i, pe_exp);

	// shadow words follow every write that is meant for this tile.
	always @(posedge clk) begin
		if (reset) begin
			sb_sh     <= '0;
			cb_sh     <= '0;
			pe_sh     <= '0;
			exp_rdata <= '0;
			exp_err   <= 1'b0;
			pe_q      <= '0;
		end else begin
			pe_q <= pe_now;
			if (cfg_we_i && hit && cfg_addr_i.blk == SB) sb_sh <= cfg_wdata_i;
			if (cfg_we_i && hit && cfg_addr_i.blk == CB) cb_sh <= cfg_wdata_i;
			if (cfg_we_i && hit && cfg_addr_i.blk == PE) pe_sh <= cfg_wdata_i;
			if (cfg_re_i && hit) begin
				exp_rdata <= (cfg_addr_i.blk == SB) ? sb_sh :
				             (cfg_addr_i.blk == CB) ? cb_sh :
				             (cfg_addr_i.blk == PE) ? pe_sh : '0;
			end
			if ((cfg_we_i || cfg_re_i) && hit && cfg_addr_i.blk == NONE) exp_err <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// port checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_out_tracks: assert property (@(posedge clk) disable iff (reset) out_tracks_i == exp_out)
		else begin
			fail_cnt++;
			$display("Mismatch at %0t: out_tracks_o expected %h, actual %h",
				$time, $sampled(exp_out), $sampled(out_tracks_i));
		end

	a_rdata: assert property (@(posedge clk) disable iff (reset) cfg_rdata_i == exp_rdata)
		else begin
			fail_cnt++;
			$display("Mismatch at %0t: cfg_rdata_o expected %h, actual %h",
				$time, $sampled(exp_rdata), $sampled(cfg_rdata_i));
		end

	a_err: assert property (@(posedge clk) disable iff (reset) cfg_err_i == exp_err)
		else begin
			fail_cnt++;
			$display("Mismatch at %0t: cfg_err_o expected %b, actual %b",
				$time, $sampled(exp_err), $sampled(cfg_err_i));
		end

	assign fail_cnt_o = fail_cnt;

endmodule

// File: dv/cgra_tile_tb.sv
module cgra_tile_tb;

	import cgra_pkg::*;

	localparam logic [5:0] TILE    = 6'd5;
	localparam logic [5:0] OTHER   = 6'd6;
	localparam int         N_ROUTE = 40;
	localparam int         TRK_CHG = 6; // track changes after each new word.
	// reset, readback, routing, pe ops and address tests in that order.
	localparam int TEST_CYCLES = 10 + 8 + N_ROUTE*(1 + TRK_CHG) + 16*(3 + TRK_CHG) + 14;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic         clk;
	logic         reset;
	logic         cfg_we;
	logic         cfg_re;
	cfg_addr_t    cfg_addr;
	cfg_word_u    cfg_wdata;
	cfg_word_u    cfg_rdata;
	logic         cfg_err;
	tile_tracks_t in_tracks;
	tile_tracks_t out_tracks;
	logic [31:0]  rng;
	int           fail_cnt;
	int           fails_before;
	int           tests_passed;
	int           tests_failed;
	int           cycles = 0;

	cgra_tile #(.TILE_ID(TILE)) u_cgra_tile (
		.clk(clk), .reset(reset), .cfg_we_i(cfg_we), .cfg_re_i(cfg_re),
		.cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata), .cfg_rdata_o(cfg_rdata),
		.cfg_err_o(cfg_err), .in_tracks_i(in_tracks), .out_tracks_o(out_tracks)
	);

	cgra_tile_checks #(.TILE_ID(TILE)) u_checks (
		.clk(clk), .reset(reset), .cfg_we_i(cfg_we), .cfg_re_i(cfg_re),
		.cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata), .in_tracks_i(in_tracks),
		.out_tracks_i(out_tracks), .cfg_rdata_i(cfg_rdata), .cfg_err_i(cfg_err),
		.fail_cnt_o(fail_cnt)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic tile_tracks_t rand_tracks();
		return {next_rand(), next_rand()};
	endfunction

	task automatic step(); // inputs change one unit after the edge.
		@(posedge clk);
		#1;
	endtask

	task automatic cfg_write(input logic [5:0] tile_id, input blk_e blk_sel, input cfg_word_u word);
		cfg_we        = 1'b1;
		cfg_addr.tile = tile_id;
		cfg_addr.blk  = blk_sel;
		cfg_wdata     = word;
		step();
		cfg_we = 1'b0;
	endtask

	task automatic cfg_read(input logic [5:0] tile_id, input blk_e blk_sel);
		cfg_re        = 1'b1;
		cfg_addr.tile = tile_id;
		cfg_addr.blk  = blk_sel;
		step();
		cfg_re = 1'b0;
	endtask

	task automatic set_tracks(input tile_tracks_t tr);
		in_tracks = tr;
		step();
	endtask

	task automatic start_test();
		fails_before = fail_cnt;
	endtask

	task automatic end_test(input string name);
		if (fail_cnt == fails_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, fail_cnt - fails_before);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		cfg_word_u w;
		rng          = 32'd63101;
		reset        = 1'b1;
		cfg_we       = 1'b0;
		cfg_re       = 1'b0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		in_tracks    = '0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test();
		set_tracks(rand_tracks());
		set_tracks(rand_tracks());
		end_test("reset_state");

		// cb and pe words keep their reserved bits at zero.
		start_test();
		w.raw = next_rand();
		cfg_write(TILE, SB, w);
		w.raw = next_rand() & 32'hFF00_0000;
		cfg_write(TILE, CB, w);
		w.raw = next_rand() & 32'hFF00_0000;
		cfg_write(TILE, PE, w);
		cfg_read(TILE, SB);
		cfg_read(TILE, CB);
		cfg_read(TILE, PE);
		step();
		end_test("write_readback");

		start_test();
		for (int i = 0; i < N_ROUTE; i++) begin
			w.raw = next_rand();
			cfg_write(TILE, SB, w);
			repeat (TRK_CHG) set_tracks(rand_tracks());
		end
		end_test("routing");

		start_test();
		w.raw = '1;
		cfg_write(TILE, SB, w); // every output now carries the pe result.
		for (int op = 0; op < 8; op++) begin
			for (int oreg = 0; oreg < 2; oreg++) begin
				w.raw = next_rand() & 32'hFF00_0000;
				cfg_write(TILE, CB, w);
				w.raw          = '0;
				w.pe.op        = pe_op_e'(op);
				w.pe.out_reg   = oreg[0];
				w.pe.const_val = track_t'(next_rand());
				cfg_write(TILE, PE, w);
				repeat (TRK_CHG) set_tracks(rand_tracks());
				step();
			end
		end
		end_test("pe_operations");

		start_test();
		for (int b = 0; b < 3; b++) begin
			w.raw = next_rand() & 32'hFF00_0000;
			cfg_write(OTHER, blk_e'(b), w);
		end
		cfg_write(OTHER, NONE, w);
		cfg_read(TILE, SB);
		cfg_read(TILE, CB);
		cfg_read(TILE, PE);
		cfg_read(TILE, NONE);
		w.raw = next_rand();
		cfg_write(TILE, SB, w);
		cfg_read(TILE, SB);
		step();
		step();
		end_test("foreign_and_bad_address");

		$display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
			tests_passed, tests_failed, fail_cnt);
		if (tests_failed == 0 && fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: logic/cgra_pkg.sv
package cgra_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tile geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int NUM_SIDES  = 4; // north, east, south, west.
	localparam int NUM_TRACKS = 4;
	localparam int TRACK_W    = 4;
	localparam int CFG_W      = 32;

	typedef logic [TRACK_W-1:0] track_t;

	typedef struct packed {
		track_t [NUM_TRACKS-1:0] trk;
	} side_t;

	typedef struct packed {
		side_t north;
		side_t east;
		side_t south;
		side_t west;
	} tile_tracks_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// configuration addressing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		SB   = 2'd0,
		CB   = 2'd1,
		PE   = 2'd2,
		NONE = 2'd3 // no block here, any access is an error.
	} blk_e;

	typedef struct packed {
		logic [5:0] tile;
		blk_e       blk;
	} cfg_addr_t;

	typedef enum logic [2:0] {
		PASS_A = 3'd0,
		AND    = 3'd1,
		OR     = 3'd2,
		XOR    = 3'd3,
		ADD    = 3'd4,
		SUB    = 3'd5,
		CONST  = 3'd6,
		NOT_A  = 3'd7
	} pe_op_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// configuration word views
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// select for output side s, track t sits at index s*NUM_TRACKS+t.
	typedef logic [NUM_SIDES*NUM_TRACKS-1:0][1:0] sb_cfg_t;

	typedef struct packed {
		logic [3:0]  sel_a; // side is sel div 4, track is sel mod 4.
		logic [3:0]  sel_b;
		logic [23:0] rsvd;
	} cb_cfg_t;

	typedef struct packed {
		pe_op_e      op;
		logic        out_reg;
		track_t      const_val;
		logic [23:0] rsvd;
	} pe_cfg_t;

	typedef union packed {
		sb_cfg_t          sb;
		cb_cfg_t          cb;
		pe_cfg_t          pe;
		logic [CFG_W-1:0] raw;
	} cfg_word_u;

endpackage

// File: logic/cgra_tile.sv
module cgra_tile #(
	parameter int unsigned TILE_ID = 5
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cfg_we_i,
	input  logic                   cfg_re_i,
	input  cgra_pkg::cfg_addr_t    cfg_addr_i,
	input  cgra_pkg::cfg_word_u    cfg_wdata_i,
	output cgra_pkg::cfg_word_u    cfg_rdata_o,
	output logic                   cfg_err_o,
	input  cgra_pkg::tile_tracks_t in_tracks_i,
	output cgra_pkg::tile_tracks_t out_tracks_o
);

	import cgra_pkg::*;

	logic      sb_we;
	logic      cb_we;
	logic      pe_we;
	cfg_word_u sb_word;
	cfg_word_u cb_word;
	cfg_word_u pe_word;
	track_t    op_a;
	track_t    op_b;
	track_t    pe_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// configuration path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	config_loader #(
		.TILE_ID(TILE_ID)
	) u_config_loader (
		.clk        (clk),
		.reset      (reset),
		.cfg_we_i   (cfg_we_i),
		.cfg_re_i   (cfg_re_i),
		.cfg_addr_i (cfg_addr_i),
		.sb_we_o    (sb_we),
		.cb_we_o    (cb_we),
		.pe_we_o    (pe_we),
		.sb_word_i  (sb_word),
		.cb_word_i  (cb_word),
		.pe_word_i  (pe_word),
		.cfg_rdata_o(cfg_rdata_o),
		.cfg_err_o  (cfg_err_o)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// every block sees the same write word; only its enable decides.
	connection_box u_connection_box (
		.clk        (clk),
		.reset      (reset),
		.cfg_we_i   (cb_we),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_word_o (cb_word),
		.in_tracks_i(in_tracks_i),
		.op_a_o     (op_a),
		.op_b_o     (op_b)
	);

	pe_core u_pe_core (
		.clk        (clk),
		.reset      (reset),
		.cfg_we_i   (pe_we),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_word_o (pe_word),
		.op_a_i     (op_a),
		.op_b_i     (op_b),
		.pe_out_o   (pe_out)
	);

	switch_box u_switch_box (
		.clk         (clk),
		.reset       (reset),
		.cfg_we_i    (sb_we),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_word_o  (sb_word),
		.in_tracks_i (in_tracks_i),
		.pe_out_i    (pe_out),
		.out_tracks_o(out_tracks_o)
	);

endmodule

// File: logic/config_loader.sv
module config_loader #(
	parameter int unsigned TILE_ID = 0
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                cfg_we_i,
	input  logic                cfg_re_i,
	input  cgra_pkg::cfg_addr_t cfg_addr_i,
	output logic                sb_we_o,
	output logic                cb_we_o,
	output logic                pe_we_o,
	input  cgra_pkg::cfg_word_u sb_word_i,
	input  cgra_pkg::cfg_word_u cb_word_i,
	input  cgra_pkg::cfg_word_u pe_word_i,
	output cgra_pkg::cfg_word_u cfg_rdata_o,
	output logic                cfg_err_o
);

	import cgra_pkg::*;

	logic      hit; // strobe is meant for this tile.
	logic      bad_access;
	cfg_word_u rdata_q;
	logic      err_q;

	assign hit        = (cfg_addr_i.tile == 6'(TILE_ID));
	assign bad_access = hit && (cfg_we_i || cfg_re_i) && (cfg_addr_i.blk == NONE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign sb_we_o = cfg_we_i && hit && (cfg_addr_i.blk == SB);
	assign cb_we_o = cfg_we_i && hit && (cfg_addr_i.blk == CB);
	assign pe_we_o = cfg_we_i && hit && (cfg_addr_i.blk == PE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// readback and error
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// readback holds its value until the next read for this tile.
	always_ff @(posedge clk) begin
		if (reset) begin
			rdata_q <= '0;
		end else if (cfg_re_i && hit) begin
			case (cfg_addr_i.blk)
				SB:      rdata_q <= sb_word_i;
				CB:      rdata_q <= cb_word_i;
				PE:      rdata_q <= pe_word_i;
				default: rdata_q <= '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			err_q <= 1'b0;
		end else if (bad_access) begin
			err_q <= 1'b1; // sticky until reset.
		end
	end

	assign cfg_rdata_o = rdata_q;
	assign cfg_err_o   = err_q;

endmodule

// File: logic/connection_box.sv
module connection_box (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cfg_we_i,
	input  cgra_pkg::cfg_word_u    cfg_wdata_i,
	output cgra_pkg::cfg_word_u    cfg_word_o,
	input  cgra_pkg::tile_tracks_t in_tracks_i,
	output cgra_pkg::track_t       op_a_o,
	output cgra_pkg::track_t       op_b_o
);

	import cgra_pkg::*;

	cfg_word_u                         cfg_q;
	side_t [NUM_SIDES-1:0]             in_side;
	track_t [NUM_SIDES*NUM_TRACKS-1:0] flat; // entry s*4+t is side s, track t.

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			cfg_q <= cfg_wdata_i;
		end
	end

	assign cfg_word_o = cfg_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign in_side[0] = in_tracks_i.north;
	assign in_side[1] = in_tracks_i.east;
	assign in_side[2] = in_tracks_i.south;
	assign in_side[3] = in_tracks_i.west;

	// same bit layout, so the side array reads directly as sixteen tracks.
	assign flat = in_side;

	assign op_a_o = flat[cfg_q.cb.sel_a];
	assign op_b_o = flat[cfg_q.cb.sel_b];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reserved bits are kept free for wider selects later.
	a_cb_rsvd_zero: assert property (
		@(posedge clk) disable iff (reset)
		cfg_we_i |=> (cfg_q.cb.rsvd == '0)
	);

endmodule

// File: logic/pe_core.sv
module pe_core (
	input  logic                clk,
	input  logic                reset,
	input  logic                cfg_we_i,
	input  cgra_pkg::cfg_word_u cfg_wdata_i,
	output cgra_pkg::cfg_word_u cfg_word_o,
	input  cgra_pkg::track_t    op_a_i,
	input  cgra_pkg::track_t    op_b_i,
	output cgra_pkg::track_t    pe_out_o
);

	import cgra_pkg::*;

	cfg_word_u cfg_q;
	track_t    result;
	track_t    result_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// configuration
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			cfg_q <= cfg_wdata_i;
		end
	end

	assign cfg_word_o = cfg_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operation unit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// all results are TRACK_W wide, so add and sub wrap on their own.
	always_comb begin
		case (cfg_q.pe.op)
			PASS_A: begin
				result = op_a_i;
			end
			AND: begin
				result = op_a_i & op_b_i;
			end
			OR: begin
				result = op_a_i | op_b_i;
			end
			XOR: begin
				result = op_a_i ^ op_b_i;
			end
			ADD: begin
				result = op_a_i + op_b_i;
			end
			SUB: begin
				result = op_a_i - op_b_i;
			end
			CONST: begin
				result = cfg_q.pe.const_val; // operands are ignored.
			end
			NOT_A: begin
				result = ~op_a_i;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output stage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// the register runs every cycle and out_reg only picks which copy leaves.
	always_ff @(posedge clk) begin
		if (reset) begin
			result_q <= '0;
		end else begin
			result_q <= result;
		end
	end

	assign pe_out_o = cfg_q.pe.out_reg ? result_q : result;

	a_pe_op_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(cfg_q.pe.op)
	);

endmodule

// File: logic/switch_box.sv
module switch_box (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cfg_we_i,
	input  cgra_pkg::cfg_word_u    cfg_wdata_i,
	output cgra_pkg::cfg_word_u    cfg_word_o,
	input  cgra_pkg::tile_tracks_t in_tracks_i,
	input  cgra_pkg::track_t       pe_out_i,
	output cgra_pkg::tile_tracks_t out_tracks_o
);

	import cgra_pkg::*;

	cfg_word_u             cfg_q;
	side_t [NUM_SIDES-1:0] in_side;  // index 0 is north.
	side_t [NUM_SIDES-1:0] out_side;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// routing word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			cfg_q <= cfg_wdata_i;
		end
	end

	assign cfg_word_o = cfg_q;

	// put the named sides into side order so the rule below can use plain indices.
	assign in_side[0] = in_tracks_i.north;
	assign in_side[1] = in_tracks_i.east;
	assign in_side[2] = in_tracks_i.south;
	assign in_side[3] = in_tracks_i.west;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output multiplexers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// select k below 3 takes side (s+1+k) mod 4 on track (t+s+k) mod 4.
	// each step of k moves one side on and one track up, so the
	// three choices of an output never share a source wire.
	for (genvar s = 0; s < NUM_SIDES; s++) begin : g_side
		for (genvar t = 0; t < NUM_TRACKS; t++) begin : g_track
			localparam int IDX = s*NUM_TRACKS + t;

			track_t sel_out;

			always_comb begin
				case (cfg_q.sb[IDX])
					2'd0: sel_out = in_side[(s+1)%NUM_SIDES].trk[(t+s)%NUM_TRACKS];
					2'd1: sel_out = in_side[(s+2)%NUM_SIDES].trk[(t+s+1)%NUM_TRACKS];
					2'd2: sel_out = in_side[(s+3)%NUM_SIDES].trk[(t+s+2)%NUM_TRACKS];
					default: sel_out = pe_out_i; // select 3 is the pe result.
				endcase
			end

			assign out_side[s].trk[t] = sel_out;
		end
	end

	assign out_tracks_o.north = out_side[0];
	assign out_tracks_o.east  = out_side[1];
	assign out_tracks_o.south = out_side[2];
	assign out_tracks_o.west  = out_side[3];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// an unknown select would let X spread over the whole array.
	a_sb_cfg_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(cfg_q)
	);

endmodule
